/* filelist.f */
+incdir+include
rtl/vscale_ctrl_pkg.sv
rtl/vscale_pc_mux.sv
rtl/vscale_branch_unit.sv
rtl/vscale_imem_fetch.sv
rtl/vscale_frontend.sv
verification/vscale_frontend_sva.sv
verification/vscale_frontend_tb.sv

/* Bender.yml */
package:
  name: vscale_frontend

sources:
  - include_dirs:
      - include
    files:
      - rtl/vscale_ctrl_pkg.sv
      - rtl/vscale_pc_mux.sv
      - rtl/vscale_branch_unit.sv
      - rtl/vscale_imem_fetch.sv
      - rtl/vscale_frontend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/vscale_frontend_sva.sv
      - verification/vscale_frontend_tb.sv

/* verification/vscale_frontend_tb.sv */
`timescale 1ns/1ps
`include "vscale_settings.svh"

module vscale_frontend_tb;
   import vscale_ctrl_pkg::*;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 5;
   localparam int NUM_INSTS       = 400;
   localparam int CYCLES_PER_INST = 12;
   localparam funct3_t branch_f3 [6] = '{funct3_beq, funct3_bne, funct3_blt,
                                         funct3_bge, funct3_bltu, funct3_bgeu};

   logic  clk = 1'b0;
   logic  arst_n;
   logic  imem_req;
   xpr_t  imem_addr;
   logic  imem_ack;
   inst_t imem_rdata;
   xpr_t  rs1_data;
   xpr_t  rs2_data;
   xpr_t  handler_pc;
   xpr_t  epc;
   logic  trap;
   logic  eret;
   logic  replay;
   logic  dx_valid;
   inst_t inst_DX;
   xpr_t  PC_DX;

   // what the memory handed out and where fetch should go next
   inst_t       last_rdata;
   xpr_t        req_pc       = `VSCALE_RESET_PC;
   xpr_t        exp_addr     = `VSCALE_RESET_PC;
   logic        addr_pending = 1'b1;
   int          dx_count     = 0;
   xpr_t        rs1_val;
   int unsigned delay;

   vscale_frontend u_vscale_frontend (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic report_mismatch(input string name, input xpr_t got, input xpr_t exp);
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "%s mismatch", name);
   endtask

   task automatic abort_run(input string what);
      $display("%0t ns %s", $time, what);
      $display("Test failed");
      $fatal(1, "%s", what);
   endtask

   // random control flow mix
   // other fields scrambled with the address
   function automatic inst_t make_inst(input xpr_t addr);
      inst_t       inst;
      int unsigned kind;
      inst = $urandom ^ addr;
      kind = $urandom % 12;
      if (kind < 6) begin
         inst[6:0]   = opcode_branch;
         inst[14:12] = branch_f3[kind];
      end else if (kind == 6) begin
         // funct3 010 or 011 is no branch
         inst[6:0]   = opcode_branch;
         inst[14:13] = 2'b01;
      end else if (kind == 7) begin
         inst[6:0] = opcode_jal;
      end else if (kind == 8) begin
         inst[6:0] = opcode_jalr;
      end else begin
         inst[6:0] = (kind % 2 == 0) ? 7'b0010011 : 7'b0110011;
      end
      return inst;
   endfunction

   function automatic xpr_t next_pc(input inst_t inst, input xpr_t pc_dx, input xpr_t pc_if,
                                    input xpr_t rs1, input xpr_t rs2, input xpr_t hpc,
                                    input xpr_t epc_val, input logic tr, input logic er,
                                    input logic rp);
      xpr_t imm_b;
      xpr_t imm_j;
      xpr_t imm_i;
      xpr_t jalr_t;
      logic taken;
      imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      imm_i = {{20{inst[31]}}, inst[31:20]};
      jalr_t = rs1 + imm_i;
      case (inst[14:12])
         funct3_beq:  taken = (rs1 == rs2);
         funct3_bne:  taken = (rs1 != rs2);
         funct3_blt:  taken = ($signed(rs1) < $signed(rs2));
         funct3_bge:  taken = ($signed(rs1) >= $signed(rs2));
         funct3_bltu: taken = (rs1 < rs2);
         funct3_bgeu: taken = (rs1 >= rs2);
         default:     taken = 1'b0;
      endcase
      return tr ? hpc :
             er ? epc_val :
             rp ? pc_if :
             (inst[6:0] == opcode_jal) ? pc_dx + imm_j :
             (inst[6:0] == opcode_jalr) ? jalr_t - xpr_t'(jalr_t[0]) :
             (inst[6:0] == opcode_branch && taken) ? pc_dx + imm_b : pc_if + 32'd4;
   endfunction

   initial begin
      void'($urandom(32'h100f_3852));
      arst_n     <= 1'b0;
      imem_ack   <= 1'b0;
      imem_rdata <= '0;
      rs1_data   <= '0;
      rs2_data   <= '0;
      handler_pc <= '0;
      epc        <= '0;
      trap       <= 1'b0;
      eret       <= 1'b0;
      replay     <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      wait (dx_count == NUM_INSTS && !addr_pending);
      @(posedge clk);
      if (u_vscale_frontend.u_sva.fail_count == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         abort_run("a bound handshake assertion failed");
      end
   end

   // four-phase memory
   // 0 to 3 cycles before each ack edge
   initial begin
      forever begin
         @(posedge clk);
         if (arst_n && imem_req && !imem_ack) begin
            delay = $urandom % 4;
            repeat (delay) @(posedge clk);
            last_rdata = make_inst(imem_addr);
            imem_rdata <= last_rdata;
            imem_ack   <= 1'b1;
            @(posedge clk);
            while (imem_req) begin
               @(posedge clk);
            end
            delay = $urandom % 4;
            repeat (delay) @(posedge clk);
            imem_ack <= 1'b0;
         end
      end
   end

   // fresh operands and rare redirect flags every cycle
   always @(posedge clk) begin
      rs1_val = $urandom;
      rs1_data   <= rs1_val;
      rs2_data   <= ($urandom % 4 == 0) ? rs1_val : xpr_t'($urandom);
      handler_pc <= $urandom & ~32'h3;
      epc        <= $urandom & ~32'h3;
      trap       <= ($urandom % 16 == 0);
      eret       <= ($urandom % 12 == 0);
      replay     <= ($urandom % 10 == 0);
   end

   always @(posedge clk) begin
      assert (u_vscale_frontend.u_sva.fail_count == 0)
         else abort_run("a bound handshake assertion failed");
      if (arst_n && dx_valid) begin
         assert (!addr_pending) else abort_run("dx_valid came without a new fetch");
         assert (inst_DX == last_rdata) else report_mismatch("inst_DX", inst_DX, last_rdata);
         assert (PC_DX == req_pc) else report_mismatch("PC_DX", PC_DX, req_pc);
         exp_addr     = next_pc(last_rdata, req_pc, req_pc, rs1_data, rs2_data, handler_pc,
                                epc, trap, eret, replay);
         addr_pending = 1'b1;
         dx_count     = dx_count + 1;
      end else if (arst_n && imem_req && addr_pending) begin
         assert (imem_addr == exp_addr) else report_mismatch("imem_addr", imem_addr, exp_addr);
         req_pc       = exp_addr;
         addr_pending = 1'b0;
      end
   end

   initial begin
      #((NUM_INSTS * CYCLES_PER_INST + RESET_CYCLES + 4) * CLK_PERIOD);
      $display("fetch stalled, only %0d of %0d instructions reached DX", dx_count, NUM_INSTS);
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule

/* verification/vscale_frontend_sva.sv */
`timescale 1ns/1ps

module vscale_frontend_sva (
   input logic                  clk,
   input logic                  arst_n,
   input logic                  imem_req,
   input logic                  imem_ack,
   input vscale_ctrl_pkg::xpr_t imem_addr,
   input logic                  dx_valid
);
   int fail_count = 0;

   // new request only once the memory released ack
   req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(imem_req) |-> !imem_ack)
      else begin
         fail_count++;
         $error("imem_req rose while imem_ack was high");
      end

   addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
      imem_req && $past(imem_req) |-> $stable(imem_addr))
      else begin
         fail_count++;
         $error("imem_addr moved during a request");
      end

   dx_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      dx_valid |=> !dx_valid)
      else begin
         fail_count++;
         $error("dx_valid held longer than one cycle");
      end

   quiet_after_reset: assert property (@(posedge clk)
      $rose(arst_n) |-> !imem_req && !dx_valid)
      else begin
         fail_count++;
         $error("imem_req or dx_valid high right after reset");
      end

endmodule

bind vscale_frontend vscale_frontend_sva u_sva (
   .clk       (clk),
   .arst_n    (arst_n),
   .imem_req  (imem_req),
   .imem_ack  (imem_ack),
   .imem_addr (imem_addr),
   .dx_valid  (dx_valid)
);

/* rtl/vscale_frontend.sv */
`timescale 1ns/1ps

module vscale_frontend (
   input  logic                   clk,
   input  logic                   arst_n,
   output logic                   imem_req,
   output vscale_ctrl_pkg::xpr_t  imem_addr,
   input  logic                   imem_ack,
   input  vscale_ctrl_pkg::inst_t imem_rdata,
   input  vscale_ctrl_pkg::xpr_t  rs1_data,
   input  vscale_ctrl_pkg::xpr_t  rs2_data,
   input  vscale_ctrl_pkg::xpr_t  handler_pc,
   input  vscale_ctrl_pkg::xpr_t  epc,
   input  logic                   trap,
   input  logic                   eret,
   input  logic                   replay,
   output logic                   dx_valid,
   output vscale_ctrl_pkg::inst_t inst_DX,
   output vscale_ctrl_pkg::xpr_t  PC_DX
);
   import vscale_ctrl_pkg::*;

   pc_src_sel_t pc_src_sel;
   xpr_t        PC_PIF;
   xpr_t        PC_IF;

   vscale_imem_fetch u_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .imem_req   (imem_req),
      .imem_addr  (imem_addr),
      .imem_ack   (imem_ack),
      .imem_rdata (imem_rdata),
      .PC_PIF     (PC_PIF),
      .PC_IF      (PC_IF),
      .dx_valid   (dx_valid),
      .inst_DX    (inst_DX),
      .PC_DX      (PC_DX)
   );

   vscale_branch_unit u_branch (
      .inst_DX    (inst_DX),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .trap       (trap),
      .eret       (eret),
      .replay     (replay),
      .pc_src_sel (pc_src_sel)
   );

   vscale_pc_mux u_pc_mux (
      .pc_src_sel (pc_src_sel),
      .inst_DX    (inst_DX),
      .rs1_data   (rs1_data),
      .PC_IF      (PC_IF),
      .PC_DX      (PC_DX),
      .handler_pc (handler_pc),
      .epc        (epc),
      .PC_PIF     (PC_PIF)
   );

endmodule

/* rtl/vscale_imem_fetch.sv */
`timescale 1ns/1ps
`include "vscale_settings.svh"

module vscale_imem_fetch (
   input  logic                   clk,
   input  logic                   arst_n,
   output logic                   imem_req,
   output vscale_ctrl_pkg::xpr_t  imem_addr,
   input  logic                   imem_ack,
   input  vscale_ctrl_pkg::inst_t imem_rdata,
   input  vscale_ctrl_pkg::xpr_t  PC_PIF,
   output vscale_ctrl_pkg::xpr_t  PC_IF,
   output logic                   dx_valid,
   output vscale_ctrl_pkg::inst_t inst_DX,
   output vscale_ctrl_pkg::xpr_t  PC_DX
);
   import vscale_ctrl_pkg::*;

   fetch_state_t state;
   fetch_state_t state_next;
   logic         ack_seen;

   // ack observed while the request is up
   assign ack_seen = (state == s_req) && imem_ack;

   always_comb begin
      state_next = state;
      case (state)
         s_idle: begin
            state_next = s_req;
         end
         s_req: begin
            if (imem_ack) begin
               state_next = s_ack_low;
            end
         end
         // memory must release ack before the next request
         s_ack_low: begin
            if (!imem_ack) begin
               state_next = s_dx;
            end
         end
         s_dx: begin
            state_next = s_req;
         end
         default: begin
            state_next = s_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= s_idle;
      end else begin
         state <= state_next;
      end
   end

   // fetch address only moves once the instruction has left DX
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         PC_IF <= `VSCALE_RESET_PC;
      end else if (state == s_dx) begin
         PC_IF <= PC_PIF;
      end
   end

   // instruction and its address captured on the ack edge
   always_ff @(posedge clk) begin
      if (ack_seen) begin
         inst_DX <= imem_rdata;
         PC_DX   <= PC_IF;
      end
   end

   assign imem_req  = (state == s_req);
   assign imem_addr = PC_IF;

   // execute side sees the instruction for one cycle only
   assign dx_valid = (state == s_dx);

endmodule

/* rtl/vscale_branch_unit.sv */
`timescale 1ns/1ps

module vscale_branch_unit (
   input  vscale_ctrl_pkg::inst_t       inst_DX,
   input  vscale_ctrl_pkg::xpr_t        rs1_data,
   input  vscale_ctrl_pkg::xpr_t        rs2_data,
   input  logic                         trap,
   input  logic                         eret,
   input  logic                         replay,
   output vscale_ctrl_pkg::pc_src_sel_t pc_src_sel
);
   import vscale_ctrl_pkg::*;

   opcode_t opcode;
   funct3_t funct3;
   logic    is_branch;
   logic    is_jal;
   logic    is_jalr;
   logic    cmp_eq;
   logic    cmp_lt;
   logic    cmp_ltu;
   logic    branch_taken;

   assign opcode = inst_DX[6:0];
   assign funct3 = inst_DX[14:12];

   assign is_branch = (opcode == opcode_branch);
   assign is_jal    = (opcode == opcode_jal);
   assign is_jalr   = (opcode == opcode_jalr);

   // one equality and two magnitude compares cover all six branches
   assign cmp_eq  = (rs1_data == rs2_data);
   assign cmp_lt  = ($signed(rs1_data) < $signed(rs2_data));
   assign cmp_ltu = (rs1_data < rs2_data);

   always_comb begin
      case (funct3)
         funct3_beq: begin
            branch_taken = cmp_eq;
         end
         funct3_bne: begin
            branch_taken = !cmp_eq;
         end
         funct3_blt: begin
            branch_taken = cmp_lt;
         end
         funct3_bge: begin
            branch_taken = !cmp_lt;
         end
         funct3_bltu: begin
            branch_taken = cmp_ltu;
         end
         funct3_bgeu: begin
            branch_taken = !cmp_ltu;
         end
         // undefined compare falls through
         default: begin
            branch_taken = 1'b0;
         end
      endcase
   end

   // exceptions outrank anything the instruction asks for
   always_comb begin
      if (trap) begin
         pc_src_sel = pc_handler;
      end else if (eret) begin
         pc_src_sel = pc_epc;
      end else if (replay) begin
         pc_src_sel = pc_replay;
      end else if (is_jal) begin
         pc_src_sel = pc_jal;
      end else if (is_jalr) begin
         pc_src_sel = pc_jalr;
      end else if (is_branch && branch_taken) begin
         pc_src_sel = pc_branch;
      end else begin
         pc_src_sel = pc_plus4;
      end
   end

endmodule

/* rtl/vscale_pc_mux.sv */
`timescale 1ns/1ps

module vscale_pc_mux (
   input  vscale_ctrl_pkg::pc_src_sel_t pc_src_sel,
   input  vscale_ctrl_pkg::inst_t       inst_DX,
   input  vscale_ctrl_pkg::xpr_t        rs1_data,
   input  vscale_ctrl_pkg::xpr_t        PC_IF,
   input  vscale_ctrl_pkg::xpr_t        PC_DX,
   input  vscale_ctrl_pkg::xpr_t        handler_pc,
   input  vscale_ctrl_pkg::xpr_t        epc,
   output vscale_ctrl_pkg::xpr_t        PC_PIF
);
   import vscale_ctrl_pkg::*;

   xpr_t imm_b;
   xpr_t imm_j;
   xpr_t imm_i;
   xpr_t base;
   xpr_t offset;
   xpr_t sum;

   // sign-extended immediates of the control flow formats
   assign imm_b = {{20{inst_DX[31]}}, inst_DX[7], inst_DX[30:25], inst_DX[11:8], 1'b0};
   assign imm_j = {{12{inst_DX[31]}}, inst_DX[19:12], inst_DX[20], inst_DX[30:21], 1'b0};
   assign imm_i = {{20{inst_DX[31]}}, inst_DX[31:20]};

   always_comb begin
      case (pc_src_sel)
         pc_branch: begin
            base   = PC_DX;
            offset = imm_b;
         end
         pc_jal: begin
            base   = PC_DX;
            offset = imm_j;
         end
         pc_jalr: begin
            base   = rs1_data;
            offset = imm_i;
         end
         pc_replay: begin
            base   = PC_IF;
            offset = '0;
         end
         pc_handler: begin
            base   = handler_pc;
            offset = '0;
         end
         pc_epc: begin
            base   = epc;
            offset = '0;
         end
         default: begin
            base   = PC_IF;
            offset = xpr_t'(4);
         end
      endcase
   end

   assign sum = base + offset;

   // jalr target always lands on an even address
   assign PC_PIF = (pc_src_sel == pc_jalr) ? (sum & ~xpr_t'(1)) : sum;

endmodule

/* rtl/vscale_ctrl_pkg.sv */
`include "vscale_settings.svh"

package vscale_ctrl_pkg;

   // words with a meaning of their own
   typedef logic [`VSCALE_XPR_LEN-1:0]      xpr_t;
   typedef logic [`VSCALE_INST_WIDTH-1:0]   inst_t;
   typedef logic [`VSCALE_OPCODE_WIDTH-1:0] opcode_t;
   typedef logic [`VSCALE_FUNCT3_WIDTH-1:0] funct3_t;

   // next fetch address source
   typedef enum logic [2:0] {
      pc_plus4   = 3'd0,
      pc_branch  = 3'd1,
      pc_jal     = 3'd2,
      pc_jalr    = 3'd3,
      pc_replay  = 3'd4,
      pc_handler = 3'd5,
      pc_epc     = 3'd6
   } pc_src_sel_t;

   // four-phase fetch sequence
   typedef enum logic [1:0] {
      s_idle    = 2'd0,
      s_req     = 2'd1,
      s_ack_low = 2'd2,
      s_dx      = 2'd3
   } fetch_state_t;

   // control flow opcodes
   localparam opcode_t opcode_branch = 7'b1100011;
   localparam opcode_t opcode_jal    = 7'b1101111;
   localparam opcode_t opcode_jalr   = 7'b1100111;

   // branch compare selects
   // 3'b010 and 3'b011 stay undefined
   localparam funct3_t funct3_beq  = 3'b000;
   localparam funct3_t funct3_bne  = 3'b001;
   localparam funct3_t funct3_blt  = 3'b100;
   localparam funct3_t funct3_bge  = 3'b101;
   localparam funct3_t funct3_bltu = 3'b110;
   localparam funct3_t funct3_bgeu = 3'b111;

endpackage

/* include/vscale_settings.svh */
`ifndef VSCALE_SETTINGS_SVH
`define VSCALE_SETTINGS_SVH

// width of a data word and of every address
`define VSCALE_XPR_LEN 32

// width of one instruction word
`define VSCALE_INST_WIDTH 32

// address of the first fetch after reset
`define VSCALE_RESET_PC 32'h0000_0200

// fields of an instruction that the front end decodes
`define VSCALE_OPCODE_WIDTH 7
`define VSCALE_FUNCT3_WIDTH 3

`endif
